// File: flist.f
rtl/vlane_pkg.sv
rtl/vlane_decode.sv
rtl/vlane_addsub.sv
rtl/vlane_compare.sv
rtl/vlane_shift.sv
rtl/vlane_mul.sv
rtl/vlane_result.sv
rtl/vlane_fu.sv
testbench/tb_vlane_fu.sv

// File: rtl/vlane_addsub.sv
// lane add unit: per-element wrapping and saturating add and subtract, registered
`timescale 1ns/1ns
`default_nettype none

module vlane_addsub import vlane_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  vop_e  op_i,
    input  sew_e  sew_i,
    input  data_t vs1_i,
    input  data_t vs2_i,
    output data_t res_o
);

    int unsigned        w;             // element width
    logic               sgn;           // signed saturation
    logic               sat;           // clamp enabled
    logic signed [65:0] a, b, r;       // extended element math
    logic signed [65:0] hi, lo;        // clamp limits
    data_t              res_d;

    assign sgn = (op_i == VSADD) || (op_i == VSSUB);
    assign sat = op_i inside {VSADDU, VSADD, VSSUBU, VSSUB};

    always_comb begin
        w     = sew_width(sew_i);
        res_d = '0;
        a     = '0;
        b     = '0;
        r     = '0;
        hi    = sgn ? 66'(elem_mask(w) >> 1) : 66'(elem_mask(w));
        lo    = sgn ? -hi - 1 : '0;
        for (int unsigned e = 0; e < MAX_ELEM; e++) begin
            if (e < DATA_W / w) begin
                a = elem_ext(vs2_i, e, w, sgn);
                b = elem_ext(vs1_i, e, w, sgn);
                case (op_i)
                    VADD, VSADDU, VSADD: r = a + b;
                    VSUB, VSSUBU, VSSUB: r = a - b;
                    VRSUB:               r = b - a;      // reversed
                    default:             r = '0;
                endcase
                if (sat && r > hi)
                    r = hi;
                if (sat && r < lo)
                    r = lo;
                res_d |= (data_t'(r) & elem_mask(w)) << (e * w);   // carry stops here
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            res_o <= '0;
        else
            res_o <= res_d;
    end

    function automatic logic sat_ge(data_t res, data_t src, sew_e sew);
        int unsigned wd;
        logic        ok;
        wd = sew_width(sew);
        ok = 1'b1;
        for (int unsigned e = 0; e < MAX_ELEM; e++) begin
            if (e < DATA_W / wd && elem_ext(res, e, wd, 1'b0) < elem_ext(src, e, wd, 1'b0))
                ok = 1'b0;
        end
        return ok;
    endfunction

    a_saddu_floor: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) && $past(op_i) == VSADDU |-> sat_ge(res_o, $past(vs2_i), $past(sew_i)));

endmodule

`default_nettype wire

// File: rtl/vlane_compare.sv
// lane compare unit: per-element min, max and compare-to-mask, registered
`timescale 1ns/1ns
`default_nettype none

module vlane_compare import vlane_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  vop_e  op_i,
    input  sew_e  sew_i,
    input  data_t vs1_i,
    input  data_t vs2_i,
    output data_t res_o
);

    int unsigned         w;
    logic                sgn;          // signed compare
    logic                lt;           // vs2 element below vs1 element
    logic signed [65:0]  a, b;
    logic [MAX_ELEM-1:0] mask_d;       // one bit per element
    data_t               mm_d;         // min/max result
    data_t               res_d;

    assign sgn = op_i inside {VMIN, VMAX, VMSLT};

    always_comb begin
        w      = sew_width(sew_i);
        mask_d = '0;
        mm_d   = '0;
        a      = '0;
        b      = '0;
        lt     = 1'b0;
        for (int unsigned e = 0; e < MAX_ELEM; e++) begin
            if (e < DATA_W / w) begin
                a  = elem_ext(vs2_i, e, w, sgn);
                b  = elem_ext(vs1_i, e, w, sgn);
                lt = a < b;
                mm_d |= (data_t'((lt ^ (op_i inside {VMAX, VMAXU})) ? a : b)
                         & elem_mask(w)) << (e * w);    // max picks the other side
                case (op_i)
                    VMSEQ:        mask_d[e] = (a == b);
                    VMSNE:        mask_d[e] = (a != b);
                    VMSLT, VMSLTU: mask_d[e] = lt;
                    default:      mask_d[e] = 1'b0;
                endcase
            end
        end
        case (op_i)
            VMIN, VMINU, VMAX, VMAXU:   res_d = mm_d;
            VMSEQ, VMSNE, VMSLT, VMSLTU: res_d = data_t'(mask_d);   // upper bits zero
            default:                    res_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            res_o <= '0;
        else
            res_o <= res_d;
    end

endmodule

`default_nettype wire

// File: rtl/vlane_decode.sv
// lane decode: captures the issued instruction, classifies it and forwards it one stage
`timescale 1ns/1ns
`default_nettype none

module vlane_decode import vlane_pkg::*; (
    input  logic   clk_i,          // lane clock
    input  logic   rst_n_i,        // sync reset, active low
    input  logic   valid_i,        // issue strobe
    input  vop_e   op_i,
    input  sew_e   sew_i,
    input  data_t  vs1_i,          // second operand
    input  data_t  vs2_i,          // first operand
    input  fu_id_t fu_id_i,        // lane index
    output logic   dec_valid_o,
    output vop_e   dec_op_o,
    output unit_e  dec_unit_o,
    output sew_e   dec_sew_o,
    output data_t  dec_vs1_o,
    output data_t  dec_vs2_o,
    output logic   ex_valid_o,     // aligned with unit results
    output vop_e   ex_op_o,
    output unit_e  ex_unit_o,
    output sew_e   ex_sew_o,
    output data_t  ex_vs1_o,
    output data_t  ex_vs2_o,
    output fu_id_t ex_fu_id_o
);

    fu_id_t dec_fu_id;             // index waiting for the ex stage

    function automatic unit_e classify(vop_e op);
        case (op)
            VADD, VSUB, VRSUB, VSADDU, VSADD, VSSUBU, VSSUB: return UNIT_ADD;
            VMIN, VMINU, VMAX, VMAXU, VMSEQ, VMSNE, VMSLT, VMSLTU: return UNIT_CMP;
            VSLL, VSRL, VSRA:    return UNIT_SHF;
            VMUL, VMULH, VMULHU: return UNIT_MUL;
            VAND, VOR, VXOR:     return UNIT_LOGIC;
            VID:                 return UNIT_ID;
            VMV:                 return UNIT_MOVE;
            default:             return UNIT_NONE;   // unknown encoding
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            dec_op_o    <= VNOP;
            dec_unit_o  <= UNIT_NONE;
            dec_sew_o   <= SEW_8;
            ex_valid_o  <= 1'b0;
            ex_op_o     <= VNOP;
            ex_unit_o   <= UNIT_NONE;
            ex_sew_o    <= SEW_8;
        end else begin
            dec_valid_o <= valid_i;
            ex_valid_o  <= dec_valid_o;
            if (valid_i) begin
                dec_op_o   <= op_i;
                dec_unit_o <= classify(op_i);
                dec_sew_o  <= sew_i;
            end
            if (dec_valid_o) begin                   // second copy for result stage
                ex_op_o   <= dec_op_o;
                ex_unit_o <= dec_unit_o;
                ex_sew_o  <= dec_sew_o;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            dec_vs1_o <= vs1_i;
            dec_vs2_o <= vs2_i;
            dec_fu_id <= fu_id_i;
        end
        if (dec_valid_o) begin
            ex_vs1_o   <= dec_vs1_o;
            ex_vs2_o   <= dec_vs2_o;
            ex_fu_id_o <= dec_fu_id;
        end
    end

    a_dec_sew_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o |-> !$isunknown(dec_sew_o));

endmodule

`default_nettype wire

// File: rtl/vlane_fu.sv
// vector lane top: decode, four execute units and result stage in a three-edge pipeline
`timescale 1ns/1ns
`default_nettype none

module vlane_fu import vlane_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   valid_i,
    input  vop_e   op_i,
    input  sew_e   sew_i,
    input  data_t  vs1_i,
    input  data_t  vs2_i,
    input  fu_id_t fu_id_i,
    output logic   valid_o,
    output data_t  result_o
);

    vop_e   dec_op;
    sew_e   dec_sew;
    data_t  dec_vs1, dec_vs2;
    logic   ex_valid;
    vop_e   ex_op;
    unit_e  ex_unit;
    sew_e   ex_sew;
    data_t  ex_vs1, ex_vs2;
    fu_id_t ex_fu_id;
    data_t  add_res, cmp_res, shf_res, mul_res;

    vlane_decode u_decode (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .valid_i (valid_i), .op_i (op_i),
        .sew_i (sew_i), .vs1_i (vs1_i), .vs2_i (vs2_i), .fu_id_i (fu_id_i),
        .dec_valid_o (), .dec_op_o (dec_op), .dec_unit_o (), .dec_sew_o (dec_sew),
        .dec_vs1_o (dec_vs1), .dec_vs2_o (dec_vs2),
        .ex_valid_o (ex_valid), .ex_op_o (ex_op), .ex_unit_o (ex_unit), .ex_sew_o (ex_sew),
        .ex_vs1_o (ex_vs1), .ex_vs2_o (ex_vs2), .ex_fu_id_o (ex_fu_id)
    );

    vlane_addsub u_addsub (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .op_i (dec_op), .sew_i (dec_sew),
        .vs1_i (dec_vs1), .vs2_i (dec_vs2), .res_o (add_res)
    );

    vlane_compare u_compare (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .op_i (dec_op), .sew_i (dec_sew),
        .vs1_i (dec_vs1), .vs2_i (dec_vs2), .res_o (cmp_res)
    );

    vlane_shift u_shift (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .op_i (dec_op), .sew_i (dec_sew),
        .vs1_i (dec_vs1), .vs2_i (dec_vs2), .res_o (shf_res)
    );

    vlane_mul u_mul (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .op_i (dec_op), .sew_i (dec_sew),
        .vs1_i (dec_vs1), .vs2_i (dec_vs2), .res_o (mul_res)
    );

    vlane_result u_result (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .ex_valid_i (ex_valid), .ex_unit_i (ex_unit),
        .ex_op_i (ex_op), .ex_sew_i (ex_sew), .ex_vs1_i (ex_vs1), .ex_vs2_i (ex_vs2),
        .ex_fu_id_i (ex_fu_id), .add_res_i (add_res), .cmp_res_i (cmp_res),
        .shf_res_i (shf_res), .mul_res_i (mul_res),
        .valid_o (valid_o), .result_o (result_o)
    );

endmodule

`default_nettype wire

// File: rtl/vlane_mul.sv
// lane multiplier: registered double-width element products, low or high half select
`timescale 1ns/1ns
`default_nettype none

module vlane_mul import vlane_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  vop_e  op_i,
    input  sew_e  sew_i,
    input  data_t vs1_i,
    input  data_t vs2_i,
    output data_t res_o            // half select, comb from stage two
);

    typedef logic [2*DATA_W-1:0] prod_t;   // packed element products

    int unsigned         w_d, w_q;
    logic                sgn;              // vmulh is the only signed form
    logic signed [65:0]  a, b;
    logic signed [131:0] p;                // full element product
    prod_t               pmask;
    prod_t               prod_d, prod_q;
    vop_e                op_q;
    sew_e                sew_q;
    data_t               half;

    assign sgn = (op_i == VMULH);

    always_comb begin
        w_d    = sew_width(sew_i);
        pmask  = (2 * w_d >= 2 * DATA_W) ? '1 : (prod_t'(1) << (2 * w_d)) - 1'b1;
        prod_d = '0;
        a      = '0;
        b      = '0;
        p      = '0;
        for (int unsigned e = 0; e < MAX_ELEM; e++) begin
            if (e < DATA_W / w_d) begin
                a = elem_ext(vs2_i, e, w_d, sgn);
                b = elem_ext(vs1_i, e, w_d, sgn);
                p = a * b;
                prod_d |= (prod_t'(p) & pmask) << (e * 2 * w_d);   // 2*SEW slot
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_q  <= VNOP;
            sew_q <= SEW_8;
        end else begin
            op_q  <= op_i;
            sew_q <= sew_i;
        end
        prod_q <= prod_d;
    end

    always_comb begin
        w_q   = sew_width(sew_q);
        res_o = '0;
        half  = '0;
        for (int unsigned e = 0; e < MAX_ELEM; e++) begin
            if (e < DATA_W / w_q) begin
                half = data_t'(prod_q >> (e * 2 * w_q + ((op_q == VMUL) ? 0 : w_q)));
                res_o |= (half & elem_mask(w_q)) << (e * w_q);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/vlane_pkg.sv
// vector lane package: operation, element width and unit encodings with element helpers
`default_nettype none

package vlane_pkg;

    localparam int DATA_W     = 64;              // lane datapath width
    localparam int LANES      = 8;               // lanes in the vector unit
    localparam int FU_ID_W    = $clog2(LANES);   // lane index width
    localparam int MAX_ELEM   = DATA_W / 8;      // elements per lane at SEW 8
    localparam int PIPE_DEPTH = 3;               // issue to result, in edges

    typedef logic [DATA_W-1:0]  data_t;          // operand or result
    typedef logic [FU_ID_W-1:0] fu_id_t;         // lane index

    typedef enum logic [4:0] {
        VADD = 5'd0, VSUB, VRSUB,                // wrapping
        VSADDU, VSADD, VSSUBU, VSSUB,            // saturating
        VMIN, VMINU, VMAX, VMAXU,
        VMSEQ, VMSNE, VMSLT, VMSLTU,             // mask producing
        VSLL, VSRL, VSRA,
        VMUL, VMULH, VMULHU,
        VAND, VOR, VXOR,
        VID, VMV,
        VNOP = 5'h1f                             // illegal encoding
    } vop_e;

    typedef enum logic [1:0] {SEW_8, SEW_16, SEW_32, SEW_64} sew_e;

    typedef enum logic [2:0] {
        UNIT_ADD, UNIT_CMP, UNIT_SHF, UNIT_MUL,
        UNIT_LOGIC, UNIT_ID, UNIT_MOVE, UNIT_NONE
    } unit_e;

    function automatic int unsigned sew_width(sew_e sew);
        return 32'd8 << sew;                     // 8, 16, 32, 64
    endfunction

    function automatic data_t elem_mask(int unsigned w);
        return (w >= DATA_W) ? '1 : (data_t'(1) << w) - 1'b1;
    endfunction

    // element idx of width w, sign or zero extended to 66 bits
    function automatic logic [65:0] elem_ext(data_t v, int unsigned idx, int unsigned w,
                                             logic sgn);
        data_t t;
        logic  neg;
        t   = (v >> (idx * w)) & elem_mask(w);
        neg = sgn & t[w-1];                      // element msb
        return neg ? {2'b11, t | ~elem_mask(w)} : {2'b00, t};
    endfunction

endpackage

`default_nettype wire

// File: rtl/vlane_result.sv
// lane result stage: picks the unit result, handles logic, vid and move, registers output
`timescale 1ns/1ns
`default_nettype none

module vlane_result import vlane_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   ex_valid_i,
    input  unit_e  ex_unit_i,
    input  vop_e   ex_op_i,
    input  sew_e   ex_sew_i,
    input  data_t  ex_vs1_i,
    input  data_t  ex_vs2_i,
    input  fu_id_t ex_fu_id_i,
    input  data_t  add_res_i,
    input  data_t  cmp_res_i,
    input  data_t  shf_res_i,
    input  data_t  mul_res_i,
    output logic   valid_o,
    output data_t  result_o
);

    int unsigned w;
    data_t       id_d;             // element indices for vid
    data_t       res_d;

    always_comb begin
        w    = sew_width(ex_sew_i);
        id_d = '0;
        for (int unsigned e = 0; e < MAX_ELEM; e++) begin
            if (e < DATA_W / w)
                id_d |= ((data_t'(ex_fu_id_i) * (DATA_W / w) + e) & elem_mask(w)) << (e * w);
        end
        case (ex_unit_i)
            UNIT_ADD:   res_d = add_res_i;
            UNIT_CMP:   res_d = cmp_res_i;
            UNIT_SHF:   res_d = shf_res_i;
            UNIT_MUL:   res_d = mul_res_i;
            UNIT_LOGIC: begin
                case (ex_op_i)
                    VAND:    res_d = ex_vs1_i & ex_vs2_i;
                    VOR:     res_d = ex_vs1_i | ex_vs2_i;
                    VXOR:    res_d = ex_vs1_i ^ ex_vs2_i;
                    default: res_d = '0;
                endcase
            end
            UNIT_ID:    res_d = id_d;
            UNIT_MOVE:  res_d = ex_vs1_i;  // vmv takes vs1
            default:    res_d = '0;        // vnop
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= ex_valid_i;
            if (ex_valid_i)
                result_o <= res_d;         // holds between results
        end
    end

    a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(valid_o));

endmodule

`default_nettype wire

// File: rtl/vlane_shift.sv
// lane shift unit: per-element logical and arithmetic shifts, registered
`timescale 1ns/1ns
`default_nettype none

module vlane_shift import vlane_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  vop_e  op_i,
    input  sew_e  sew_i,
    input  data_t vs1_i,           // shift amounts
    input  data_t vs2_i,           // values shifted
    output data_t res_o
);

    int unsigned        w;
    logic signed [65:0] a, b, r;
    logic [5:0]         amt;       // low log2(SEW) bits only
    data_t              res_d;

    always_comb begin
        w     = sew_width(sew_i);
        res_d = '0;
        a     = '0;
        b     = '0;
        r     = '0;
        amt   = '0;
        for (int unsigned e = 0; e < MAX_ELEM; e++) begin
            if (e < DATA_W / w) begin
                a   = elem_ext(vs2_i, e, w, op_i == VSRA);   // sign fill for sra
                b   = elem_ext(vs1_i, e, w, 1'b0);
                amt = b[5:0] & 6'(w - 1);
                case (op_i)
                    VSLL:    r = a << amt;
                    VSRL:    r = a >> amt;
                    VSRA:    r = a >>> amt;
                    default: r = '0;
                endcase
                res_d |= (data_t'(r) & elem_mask(w)) << (e * w);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            res_o <= '0;
        else
            res_o <= res_d;
    end

endmodule

`default_nettype wire

// File: testbench/tb_vlane_fu.sv
// vector lane testbench that checks directed op streams against a per-element model
`timescale 1ns/1ns
`default_nettype none

module tb_vlane_fu import vlane_pkg::*; ();

    localparam int LATENCY    = 3;         // edges from issue to valid_o
    localparam int MAX_CYCLES = 2000;      // summed test length is about 700 cycles

    logic   clk;
    logic   rst_n;
    logic   valid;
    vop_e   op;
    sew_e   sew;
    data_t  vs1, vs2;
    fu_id_t fu_id;
    logic   res_valid;
    data_t  result;

    integer seed;
    int     cyc = 0;                       // posedge count
    int     errors;
    int     checks;
    data_t  exp_q[$];                      // expected results in issue order
    int     issue_q[$];                    // issue cycle of each
    vop_e   op_q[$];

    vlane_fu DUT (
        .clk_i (clk), .rst_n_i (rst_n), .valid_i (valid), .op_i (op), .sew_i (sew),
        .vs1_i (vs1), .vs2_i (vs2), .fu_id_i (fu_id),
        .valid_o (res_valid), .result_o (result)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                  // 4 ns period

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        wait (cyc >= MAX_CYCLES);
        $display("timeout: run stopped after %0d cycles", cyc);
        $display("Something failed");
        $finish;
    end

    function automatic data_t rand_vec();
        return {$random(seed), $random(seed)};
    endfunction

    // repeat one element value across the lane
    function automatic data_t fill_vec(sew_e s, data_t val);
        int    w;
        data_t m;
        data_t v;
        w = 8 << s;
        m = (w == 64) ? '1 : (64'd1 << w) - 1;
        v = '0;
        for (int e = 0; e < 64 / w; e++)
            v |= (val & m) << (e * w);
        return v;
    endfunction

    // reference result with a taken from vs2 and b from vs1
    function automatic data_t model_result(vop_e o, sew_e s, data_t b_vec, data_t a_vec,
                                           fu_id_t id);
        int                  w;
        int                  amt;
        data_t               m, ea, eb, res;
        logic signed [129:0] ua, ub, sa, sb, r, one, umax, smax, smin;
        w    = 8 << s;
        m    = (w == 64) ? '1 : (64'd1 << w) - 1;
        one  = 1;
        umax = (one <<< w) - 1;
        smax = (one <<< (w - 1)) - 1;
        smin = -(one <<< (w - 1));
        res  = '0;
        for (int e = 0; e < 64 / w; e++) begin
            ea  = (a_vec >> (e * w)) & m;
            eb  = (b_vec >> (e * w)) & m;
            ua  = {66'd0, ea};
            ub  = {66'd0, eb};
            sa  = ea[w-1] ? ua - (one <<< w) : ua;     // two's complement view
            sb  = eb[w-1] ? ub - (one <<< w) : ub;
            amt = eb[5:0] & (w - 1);                   // low log2(sew) bits
            case (o)
                VADD:    r = ua + ub;
                VSUB:    r = ua - ub;
                VRSUB:   r = ub - ua;
                VSADDU:  r = (ua + ub > umax) ? umax : ua + ub;
                VSSUBU:  r = (ua < ub) ? 0 : ua - ub;
                VSADD:   r = sa + sb;
                VSSUB:   r = sa - sb;
                VMIN:    r = (sa < sb) ? ua : ub;
                VMINU:   r = (ua < ub) ? ua : ub;
                VMAX:    r = (sa < sb) ? ub : ua;
                VMAXU:   r = (ua < ub) ? ub : ua;
                VSLL:    r = ua << amt;
                VSRL:    r = ua >> amt;
                VSRA:    r = sa >>> amt;
                VMUL:    r = ua * ub;
                VMULHU:  r = (ua * ub) >>> w;          // upper half
                VMULH:   r = (sa * sb) >>> w;
                VID:     r = id * (64 / w) + e;
                default: r = 0;
            endcase
            if (o == VSADD || o == VSSUB) begin
                if (r > smax)
                    r = smax;
                else if (r < smin)
                    r = smin;
            end
            case (o)
                VMSEQ:   res[e] = (ea == eb);
                VMSNE:   res[e] = (ea != eb);
                VMSLT:   res[e] = (sa < sb);
                VMSLTU:  res[e] = (ea < eb);
                default: res |= (data_t'(r[63:0]) & m) << (e * w);
            endcase
        end
        case (o)
            VAND:    res = a_vec & b_vec;
            VOR:     res = a_vec | b_vec;
            VXOR:    res = a_vec ^ b_vec;
            VMV:     res = b_vec;                     // move takes vs1
            default: ;
        endcase
        return res;
    endfunction

    // wait for the falling edge and check the lane output
    task automatic tick();
        data_t exp;
        int    at;
        vop_e  o;
        @(negedge clk);
        if (res_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result seen at time %0t with no instruction in flight", $time);
            end else begin
                exp = exp_q.pop_front();
                at  = issue_q.pop_front();
                o   = op_q.pop_front();
                checks++;
                if (cyc - at != LATENCY) begin
                    errors++;
                    $display("FAILED at %0t: %s result came %0d cycles after issue",
                             $time, o.name(), cyc - at);
                end
                if (result !== exp) begin
                    errors++;
                    $display("FAILED at %0t: %s expected %h got %h", $time, o.name(), exp,
                             result);
                end
            end
        end
    endtask

    task automatic issue(vop_e o, sew_e s, data_t v1, data_t v2, fu_id_t id);
        tick();
        valid = 1'b1;
        op    = o;
        sew   = s;
        vs1   = v1;
        vs2   = v2;
        fu_id = id;
        exp_q.push_back(model_result(o, s, v1, v2, id));
        issue_q.push_back(cyc);
        op_q.push_back(o);
    endtask

    // let the pipe empty and catch anything left over
    task automatic drain();
        int n;
        n = 0;
        tick();
        valid = 1'b0;
        while (exp_q.size() > 0 && n < LATENCY + 4) begin
            tick();
            n++;
        end
        repeat (2) tick();
        if (exp_q.size() > 0) begin
            errors += exp_q.size();
            $display("%0d result(s) never appeared on valid_o", exp_q.size());
            exp_q.delete();
            issue_q.delete();
            op_q.delete();
        end
    endtask

    task automatic report(string name, int errs_before);
        if (errors == errs_before)
            $display("test %-10s passed", name);
        else
            $display("test %-10s failed with %0d errors", name, errors - errs_before);
    endtask

    // every op in [first, last] at every sew on random operands
    task automatic random_ops(vop_e first, vop_e last, int count);
        for (int k = first; k <= last; k++)
            for (int s = 0; s < 4; s++)
                repeat (count)
                    issue(vop_e'(k), sew_e'(s), rand_vec(), rand_vec(), fu_id_t'($random(seed)));
    endtask

    task automatic pipeline_stream();
        int e0;
        e0 = errors;
        if (result !== '0 || res_valid !== 1'b0) begin
            errors++;
            $display("lane outputs were not cleared by reset");
        end
        repeat (4) tick();                             // valid_o must stay low while idle
        issue(VADD, SEW_8, rand_vec(), rand_vec(), 3'd0);
        issue(VMUL, SEW_16, rand_vec(), rand_vec(), 3'd1);
        issue(VMULH, SEW_32, rand_vec(), rand_vec(), 3'd2);
        issue(VSLL, SEW_64, rand_vec(), rand_vec(), 3'd3);
        issue(VMSLT, SEW_8, rand_vec(), rand_vec(), 3'd4);
        issue(VID, SEW_16, '0, '0, 3'd3);
        issue(VMULHU, SEW_64, rand_vec(), rand_vec(), 3'd5);
        issue(VAND, SEW_8, rand_vec(), rand_vec(), 3'd6);
        issue(VSSUB, SEW_32, rand_vec(), rand_vec(), 3'd7);
        issue(VMV, SEW_8, rand_vec(), rand_vec(), 3'd0);
        issue(VMAXU, SEW_16, rand_vec(), rand_vec(), 3'd1);
        issue(VMUL, SEW_8, rand_vec(), rand_vec(), 3'd2);
        drain();
        report("pipeline", e0);
    endtask

    task automatic wrap_addsub();
        int e0;
        e0 = errors;
        random_ops(VADD, VRSUB, 5);
        for (int s = 0; s < 4; s++) begin
            issue(VADD, sew_e'(s), fill_vec(sew_e'(s), 1), '1, 3'd0);   // carry at each edge
            issue(VSUB, sew_e'(s), fill_vec(sew_e'(s), 1), '0, 3'd0);   // borrow too
        end
        drain();
        report("wrap", e0);
    endtask

    task automatic saturate_addsub();
        int    e0;
        data_t smax, smin;
        e0 = errors;
        random_ops(VSADDU, VSSUB, 3);
        for (int s = 0; s < 4; s++) begin
            smax = '1 >> (65 - (8 << s));              // largest signed element
            smin = smax + 1;
            for (int k = VSADDU; k <= VSSUB; k++) begin
                issue(vop_e'(k), sew_e'(s), fill_vec(sew_e'(s), 1), '1, 3'd0);
                issue(vop_e'(k), sew_e'(s), fill_vec(sew_e'(s), 1),
                      fill_vec(sew_e'(s), smax), 3'd0);
                issue(vop_e'(k), sew_e'(s), fill_vec(sew_e'(s), 1),
                      fill_vec(sew_e'(s), smin), 3'd0);
                issue(vop_e'(k), sew_e'(s), fill_vec(sew_e'(s), 1), '0, 3'd0);
                issue(vop_e'(k), sew_e'(s), fill_vec(sew_e'(s), smax),
                      fill_vec(sew_e'(s), smin), 3'd0);
                issue(vop_e'(k), sew_e'(s), fill_vec(sew_e'(s), smin),
                      fill_vec(sew_e'(s), smax), 3'd0);
            end
        end
        drain();
        report("saturate", e0);
    endtask

    task automatic compare_ops();
        int    e0;
        data_t a;
        data_t lo_src;                                 // source of the low half
        e0 = errors;
        random_ops(VMIN, VMSLTU, 4);
        for (int k = VMIN; k <= VMSLTU; k++)
            for (int s = 0; s < 4; s++) begin
                a      = rand_vec();
                lo_src = rand_vec();
                issue(vop_e'(k), sew_e'(s), a, a, 3'd0);                 // all equal
                issue(vop_e'(k), sew_e'(s), {a[63:32], lo_src[31:0]}, a, 3'd0);
            end
        drain();
        report("compare", e0);
    endtask

    task automatic shift_mul_ops();
        int e0;
        e0 = errors;
        random_ops(VSLL, VSRA, 5);
        random_ops(VMUL, VMULHU, 5);
        drain();
        report("shift_mul", e0);
    endtask

    task automatic logic_id_move();
        int e0;
        e0 = errors;
        random_ops(VAND, VXOR, 4);
        for (int id = 0; id < LANES; id++)
            for (int s = 0; s < 4; s++)
                issue(VID, sew_e'(s), rand_vec(), rand_vec(), fu_id_t'(id));
        for (int s = 0; s < 4; s++)
            issue(VMV, sew_e'(s), rand_vec(), rand_vec(), 3'd2);
        issue(VNOP, SEW_32, rand_vec(), rand_vec(), 3'd1);
        issue(vop_e'(5'd27), SEW_8, rand_vec(), rand_vec(), 3'd4);   // unused encoding
        drain();
        report("misc", e0);
    endtask

    initial begin
        seed   = 32'h64bb_660b;
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        valid  = 1'b0;
        op     = VNOP;
        sew    = SEW_8;
        vs1    = '0;
        vs2    = '0;
        fu_id  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        pipeline_stream();
        wrap_addsub();
        saturate_addsub();
        compare_ops();
        shift_mul_ops();
        logic_id_move();
        $display("summary: %0d results checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
